// File: Bender.yml
package:
  name: tinker_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/tinker_isa_pkg.sv
      - hdl/tinker_ctrl_pkg.sv
      - hdl/tinker_alu.sv
      - hdl/tinker_regfile.sv
      - hdl/tinker_memory.sv
      - hdl/tinker_control.sv
      - hdl/tinker_core.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_clock.sv
      - tests/tinker_core_tb.sv

// File: hdl/tinker_alu.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_alu
    import tinker_isa_pkg::*;
(
    input  opcode_t opcode,
    input  word_t   rd_data,
    input  word_t   rs_data,
    input  word_t   rt_data,
    input  lit_t    lit,
    output word_t   result
);

    word_t lit_ext;

    // immediates are zero extended
    assign lit_ext = {{(`TINKER_XLEN-`TINKER_LIT_W){1'b0}}, lit};

    always_comb begin
        case (opcode)
            // arithmetic
            OP_ADD:    result = rs_data + rt_data;
            OP_ADDI:   result = rd_data + lit_ext;
            OP_SUB:    result = rs_data - rt_data;
            OP_SUBI:   result = rd_data - lit_ext;
            OP_MUL:    result = rs_data * rt_data;  // low 64 bits kept
            // logic
            OP_AND:    result = rs_data & rt_data;
            OP_OR:     result = rs_data | rt_data;
            OP_XOR:    result = rs_data ^ rt_data;
            OP_NOT:    result = ~rs_data;
            // shifts, logical only
            OP_SHFTR:  result = rs_data >> rt_data;
            OP_SHFTRI: result = rd_data >> lit_ext;
            OP_SHFTL:  result = rs_data << rt_data;
            OP_SHFTLI: result = rd_data << lit_ext;
            // moves
            OP_MOV_RS: result = rs_data;
            OP_MOV_L:  result = {rd_data[`TINKER_XLEN-1:`TINKER_LIT_W], lit};
            default:   result = '0;
        endcase
    end

endmodule

// File: hdl/tinker_control.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_control
    import tinker_isa_pkg::*;
    import tinker_ctrl_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  addr_t                   pc,
    input  logic [`TINKER_ILEN-1:0] fetch_word,
    input  word_t                   rd_data,
    input  word_t                   rs_data,
    input  word_t                   rt_data,
    input  word_t                   load_data,
    output reg_addr_t               rd_addr,
    output reg_addr_t               rs_addr,
    output reg_addr_t               rt_addr,
    output logic                    reg_we,
    output word_t                   reg_wdata,
    output addr_t                   load_addr,
    output logic                    store_we,
    output addr_t                   store_addr,
    output word_t                   store_data,
    output addr_t                   next_pc,
    output logic                    pc_we,
    output logic                    halt_req
);

    ctrl_state_t             state, state_nxt;
    logic [`TINKER_ILEN-1:0] ir;
    addr_t                   fetch_pc;  // address of the instruction in ir
    word_t                   wb_data;   // alu result or loaded word
    opcode_t                 opcode;
    lit_t                    lit;
    word_t                   alu_result;
    addr_t                   lit_zext, lit_sext;
    addr_t                   br_target;
    logic                    br_taken, is_branch;

    // --------------------------------------------------
    // field decode
    // --------------------------------------------------
    assign opcode  = opcode_t'(ir[`TINKER_OPC_MSB -: `TINKER_OPC_W]);
    assign rd_addr = ir[`TINKER_RD_MSB -: `TINKER_REG_AW];
    assign rs_addr = ir[`TINKER_RS_MSB -: `TINKER_REG_AW];
    assign rt_addr = ir[`TINKER_RT_MSB -: `TINKER_REG_AW];
    assign lit     = ir[`TINKER_LIT_W-1:0];

    assign lit_zext = {{(`TINKER_ALEN-`TINKER_LIT_W){1'b0}}, lit};
    assign lit_sext = {{(`TINKER_ALEN-`TINKER_LIT_W){lit[`TINKER_LIT_W-1]}}, lit};

    tinker_alu alu_inst (
        .opcode  (opcode),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .lit     (lit),
        .result  (alu_result)
    );

    // data side addressing, qualified by the strobes
    assign load_addr  = rs_data[`TINKER_ALEN-1:0] + lit_zext;
    assign store_addr = rd_data[`TINKER_ALEN-1:0] + lit_zext;
    assign store_data = rs_data;
    assign reg_wdata  = wb_data;

    // branch resolution, used in DECODE only
    always_comb begin
        is_branch = 1'b1;
        br_taken  = 1'b1;
        br_target = rd_data[`TINKER_ALEN-1:0];
        case (opcode)
            OP_BR:     ;
            OP_BRR_RD: br_target = fetch_pc + rd_data[`TINKER_ALEN-1:0];
            OP_BRR_L:  br_target = fetch_pc + lit_sext;
            OP_BRNZ:   br_taken = (rs_data != '0);
            OP_BRGT:   br_taken = ($signed(rs_data) > $signed(rt_data));
            default:   is_branch = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // state machine
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        next_pc   = pc + addr_t'(4);
        pc_we     = 1'b0;
        reg_we    = 1'b0;
        store_we  = 1'b0;
        halt_req  = 1'b0;
        case (state)
            FETCH: begin
                pc_we     = 1'b1;  // sequential step
                state_nxt = DECODE;
            end
            DECODE: begin
                if (is_branch) begin
                    next_pc   = br_target;
                    pc_we     = br_taken;
                    state_nxt = FETCH;
                end else if (opcode == OP_HALT) begin
                    halt_req  = 1'b1;
                    state_nxt = HALTED;
                end else if (opcode inside {OP_LOAD, OP_STORE}) begin
                    state_nxt = MEMORY;
                end else if (opcode inside {OP_AND, OP_OR, OP_XOR, OP_NOT, OP_SHFTR,
                                            OP_SHFTRI, OP_SHFTL, OP_SHFTLI, OP_MOV_RS,
                                            OP_MOV_L, OP_ADD, OP_ADDI, OP_SUB, OP_SUBI,
                                            OP_MUL}) begin
                    state_nxt = EXECUTE;
                end else begin
                    state_nxt = FETCH;  // unknown opcode acts as nop
                end
            end
            EXECUTE:   state_nxt = WRITEBACK;
            MEMORY: begin
                store_we  = (opcode == OP_STORE);
                state_nxt = (opcode == OP_STORE) ? FETCH : WRITEBACK;
            end
            WRITEBACK: begin
                reg_we    = 1'b1;
                state_nxt = FETCH;
            end
            default:   halt_req = 1'b1;  // HALTED
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            ir    <= '0;
        end else begin
            state <= state_nxt;
            if (state == FETCH) ir <= fetch_word;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH) fetch_pc <= pc;
        if (state == EXECUTE) wb_data <= alu_result;
        else if (state == MEMORY) wb_data <= load_data;
    end

    a_wb_path: assert property (@(posedge clk) disable iff (reset)
        reg_we |-> state == WRITEBACK && $past(state) inside {EXECUTE, MEMORY}
    ) else $error("register write outside writeback");
    a_store_pulse: assert property (@(posedge clk) disable iff (reset)
        store_we |-> state == MEMORY ##1 !store_we
    ) else $error("store strobe not a single memory cycle");

endmodule

// File: hdl/tinker_core.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_core
    import tinker_isa_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    prog_we,
    input  addr_t                   prog_addr,
    input  logic [`TINKER_ILEN-1:0] prog_data,
    output logic                    hlt,
    output logic                    obs_store_we,
    output addr_t                   obs_store_addr,
    output word_t                   obs_store_data
);

    addr_t                   pc, next_pc, load_addr, store_addr;
    logic                    pc_we, halt_req, halted;
    logic                    reg_we, store_we;
    logic [`TINKER_ILEN-1:0] fetch_word;
    reg_addr_t               rd_addr, rs_addr, rt_addr;
    word_t                   rd_data, rs_data, rt_data;
    word_t                   reg_wdata, load_data, store_data;

    // --------------------------------------------------
    // pc and sticky halt
    // --------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc     <= `TINKER_RESET_PC;
            halted <= 1'b0;
        end else begin
            if (pc_we && !halted) pc <= next_pc;  // frozen once halted
            if (halt_req) halted <= 1'b1;
        end
    end

    assign hlt = halt_req | halted;

    assign obs_store_we   = store_we;
    assign obs_store_addr = store_addr;
    assign obs_store_data = store_data;

    tinker_control control_inst (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .fetch_word (fetch_word),
        .rd_data    (rd_data),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .load_data  (load_data),
        .rd_addr    (rd_addr),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .reg_we     (reg_we),
        .reg_wdata  (reg_wdata),
        .load_addr  (load_addr),
        .store_we   (store_we),
        .store_addr (store_addr),
        .store_data (store_data),
        .next_pc    (next_pc),
        .pc_we      (pc_we),
        .halt_req   (halt_req)
    );

    // writes always target the rd field
    tinker_regfile regfile_inst (
        .clk     (clk),
        .reset   (reset),
        .we      (reg_we),
        .waddr   (rd_addr),
        .wdata   (reg_wdata),
        .rd_addr (rd_addr),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rd_data (rd_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    tinker_memory memory_inst (
        .clk        (clk),
        .reset      (reset),
        .fetch_addr (pc),
        .fetch_word (fetch_word),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .store_we   (store_we),
        .store_addr (store_addr),
        .store_data (store_data),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

endmodule

// File: hdl/tinker_ctrl_pkg.sv
package tinker_ctrl_pkg;

    // multicycle sequencing, one state per cycle
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5  // parked until reset
    } ctrl_state_t;

endpackage

// File: hdl/tinker_isa_pkg.sv
`include "tinker_params.svh"

package tinker_isa_pkg;

    typedef logic [`TINKER_XLEN-1:0]   word_t;
    typedef logic [`TINKER_ALEN-1:0]   addr_t;
    typedef logic [`TINKER_REG_AW-1:0] reg_addr_t;
    typedef logic [`TINKER_LIT_W-1:0]  lit_t;

    // --------------------------------------------------
    // opcode encodings
    // --------------------------------------------------
    typedef enum logic [`TINKER_OPC_W-1:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR_RD = 5'h09,  // pc relative, offset in rd
        OP_BRR_L  = 5'h0a,  // pc relative, signed literal
        OP_BRNZ   = 5'h0b,
        OP_BRGT   = 5'h0e,
        OP_HALT   = 5'h0f,
        OP_LOAD   = 5'h10,
        OP_MOV_RS = 5'h11,
        OP_MOV_L  = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1a,
        OP_SUBI   = 5'h1b,
        OP_MUL    = 5'h1c
    } opcode_t;

endpackage

// File: hdl/tinker_memory.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_memory
    import tinker_isa_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  addr_t                   fetch_addr,
    output logic [`TINKER_ILEN-1:0] fetch_word,
    input  addr_t                   load_addr,
    output word_t                   load_data,
    input  logic                    store_we,
    input  addr_t                   store_addr,
    input  word_t                   store_data,
    input  logic                    prog_we,
    input  addr_t                   prog_addr,
    input  logic [`TINKER_ILEN-1:0] prog_data
);

    localparam int MEM_AW = $clog2(`TINKER_MEM_BYTES);
    localparam int WORD_BYTES = `TINKER_XLEN / 8;
    localparam int INSTR_BYTES = `TINKER_ILEN / 8;

    logic [7:0] mem [`TINKER_MEM_BYTES];

    // byte address wraps at the top of memory
    function automatic logic [MEM_AW-1:0] byte_idx(addr_t base, int unsigned offs);
        addr_t a;
        a = base + addr_t'(offs);
        return a[MEM_AW-1:0];
    endfunction

    // --------------------------------------------------
    // writes, little-endian
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (store_we) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[byte_idx(store_addr, i)] <= store_data[8*i +: 8];
            end
        end
        if (prog_we) begin
            for (int i = 0; i < INSTR_BYTES; i++) begin
                mem[byte_idx(prog_addr, i)] <= prog_data[8*i +: 8];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < INSTR_BYTES; i++) begin
            fetch_word[8*i +: 8] = mem[byte_idx(fetch_addr, i)];
        end
        for (int i = 0; i < WORD_BYTES; i++) begin
            load_data[8*i +: 8] = mem[byte_idx(load_addr, i)];
        end
    end

    a_no_store_in_reset: assert property (@(posedge clk) reset |-> !store_we)
        else $error("data store while reset is held");
    a_prog_only_in_reset: assert property (@(posedge clk) !reset |-> !prog_we)
        else $error("program write outside reset");

endmodule

// File: hdl/tinker_params.svh
`ifndef TINKER_PARAMS_SVH
`define TINKER_PARAMS_SVH

// datapath and instruction widths
`define TINKER_XLEN      64
`define TINKER_ILEN      32
`define TINKER_ALEN      32
`define TINKER_REG_AW    5
`define TINKER_NREGS     32
`define TINKER_LIT_W     12
`define TINKER_OPC_W     5

// memory map
`define TINKER_MEM_BYTES 65536
`define TINKER_RESET_PC  32'h0000_2000

// top bit of each instruction field
`define TINKER_OPC_MSB   31
`define TINKER_RD_MSB    26
`define TINKER_RS_MSB    21
`define TINKER_RT_MSB    16

`endif

// File: hdl/tinker_regfile.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_regfile
    import tinker_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t rd_addr,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output word_t     rd_data,
    output word_t     rs_data,
    output word_t     rt_data
);

    word_t regs [`TINKER_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // three async read ports, no bypass
    assign rd_data = regs[rd_addr];
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    a_waddr_known: assert property (
        @(posedge clk) disable iff (reset) we |-> !$isunknown(waddr)
    ) else $error("regfile write with unknown address");

endmodule

// File: tb.f
+incdir+hdl
hdl/tinker_isa_pkg.sv
hdl/tinker_ctrl_pkg.sv
hdl/tinker_alu.sv
hdl/tinker_regfile.sv
hdl/tinker_memory.sv
hdl/tinker_control.sv
hdl/tinker_core.sv
tests/tb_clock.sv
tests/tinker_core_tb.sv

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    logic por;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    // power-on reset, 8 cycles, dropped on a falling edge
    initial begin
        por = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        por = 1'b0;
    end

    assign reset = por | reset_req;

endmodule

// File: tests/tinker_core_tb.sv
`timescale 1ns/1ps
`include "tinker_params.svh"

module tinker_core_tb
    import tinker_isa_pkg::*;
    import tinker_ctrl_pkg::*;
();

    logic        clk, reset, reset_req;
    logic        prog_we;
    addr_t       prog_addr;
    logic [31:0] prog_data;
    logic        hlt, obs_store_we;
    addr_t       obs_store_addr;
    word_t       obs_store_data;

    integer      seed = 32'hc53a_8ee8;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] prog [$];
    addr_t       exp_addr [$], got_addr [$];
    word_t       exp_data [$], got_data [$];
    logic [7:0]  model_mem [0:65535];  // byte image for the reference model

    tb_clock clock_inst (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    tinker_core tinker_core_inst (
        .clk            (clk),
        .reset          (reset),
        .prog_we        (prog_we),
        .prog_addr      (prog_addr),
        .prog_data      (prog_data),
        .hlt            (hlt),
        .obs_store_we   (obs_store_we),
        .obs_store_addr (obs_store_addr),
        .obs_store_data (obs_store_data)
    );

    task automatic check(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------------------------------------
    // program building
    // --------------------------------------------------
    task automatic emit(input opcode_t op, input int rd, input int rs, input int rt,
                        input int l);
        prog.push_back({op, 5'(rd), 5'(rs), 5'(rt), 12'(l)});
    endtask

    task automatic set_small(input int r, input int l);
        emit(OP_XOR, r, r, r, 0);  // clear first, mov_l keeps upper bits
        emit(OP_MOV_L, r, 0, 0, l);
    endtask

    // 4 + 5*12 bits, top chunk first
    task automatic set_reg(input int r, input word_t v);
        set_small(r, v[63:60]);
        for (int i = 4; i >= 0; i--) begin
            emit(OP_SHFTLI, r, 0, 0, 12);
            emit(OP_MOV_L, r, 0, 0, v[12*i +: 12]);
        end
    endtask

    task automatic set_base();
        set_small(30, 12'h400);
        emit(OP_SHFTLI, 30, 0, 0, 4);  // r30 = 0x4000, data area
    endtask

    task automatic mark(input int k);
        emit(OP_STORE, 30, 6, 0, 8 * k);
    endtask

    // branch target register, literal patched once the label is known
    task automatic load_target(input int r, output int idx);
        set_small(r, 12'h200);
        emit(OP_SHFTLI, r, 0, 0, 4);
        idx = prog.size();
        emit(OP_ADDI, r, 0, 0, 0);
    endtask

    task automatic place_label(input int idx);
        prog[idx] = {prog[idx][31:12], 12'(4 * prog.size())};
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    function automatic word_t alu_model(opcode_t op, word_t d, word_t s, word_t t,
                                        logic [11:0] l);
        word_t z;
        z = {52'h0, l};
        case (op)
            OP_ADD:    return s + t;
            OP_ADDI:   return d + z;
            OP_SUB:    return s - t;
            OP_SUBI:   return d - z;
            OP_MUL:    return s * t;
            OP_AND:    return s & t;
            OP_OR:     return s | t;
            OP_XOR:    return s ^ t;
            OP_NOT:    return ~s;
            OP_SHFTR:  return s >> t;
            OP_SHFTRI: return d >> z;
            OP_SHFTL:  return s << t;
            OP_SHFTLI: return d << z;
            OP_MOV_RS: return s;
            OP_MOV_L:  return {d[63:12], l};
            default:   return '0;
        endcase
    endfunction

    task automatic predict_stores();
        word_t       r [32];
        addr_t       pc, next_pc, a;
        logic [31:0] w;
        logic [11:0] l;
        logic [15:0] bi;
        opcode_t     op;
        int          rd, rs, rt, steps;
        bit          done;
        foreach (r[i]) r[i] = '0;
        exp_addr.delete();
        exp_data.delete();
        pc = `TINKER_RESET_PC;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            w = prog[(pc - `TINKER_RESET_PC) >> 2];
            op = opcode_t'(w[31:27]);
            rd = w[26:22];
            rs = w[21:17];
            rt = w[16:12];
            l = w[11:0];
            next_pc = pc + 4;
            case (op)
                OP_HALT:   done = 1'b1;
                OP_LOAD: begin
                    a = r[rs][31:0] + {20'h0, l};
                    for (int j = 0; j < 8; j++) begin
                        bi = a[15:0] + 16'(j);
                        r[rd][8*j +: 8] = model_mem[bi];
                    end
                end
                OP_STORE: begin
                    a = r[rd][31:0] + {20'h0, l};
                    for (int j = 0; j < 8; j++) begin
                        bi = a[15:0] + 16'(j);
                        model_mem[bi] = r[rs][8*j +: 8];
                    end
                    exp_addr.push_back(a);
                    exp_data.push_back(r[rs]);
                end
                OP_BR:     next_pc = r[rd][31:0];
                OP_BRR_RD: next_pc = pc + r[rd][31:0];
                OP_BRR_L:  next_pc = pc + {{20{l[11]}}, l};
                OP_BRNZ:   if (r[rs] != 0) next_pc = r[rd][31:0];
                OP_BRGT:   if ($signed(r[rs]) > $signed(r[rt])) next_pc = r[rd][31:0];
                default:   r[rd] = alu_model(op, r[rd], r[rs], r[rt], l);
            endcase
            pc = next_pc;
            steps++;
        end
        if (!done) begin
            errors++;
            $display("reference model never reached halt");
        end
    endtask

    // --------------------------------------------------
    // DUT run and compare
    // --------------------------------------------------
    task automatic execute_program(input string name);
        int cycles;
        @(negedge clk);
        reset_req = 1'b1;
        @(negedge clk);
        foreach (prog[i]) begin
            prog_we   = 1'b1;
            prog_addr = `TINKER_RESET_PC + 4 * i;
            prog_data = prog[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        @(negedge clk);
        reset_req = 1'b0;
        got_addr.delete();
        got_data.delete();
        cycles = 0;
        while (!hlt && cycles < 8000) begin
            @(negedge clk);
            cycles++;
            if (obs_store_we) begin
                got_addr.push_back(obs_store_addr);
                got_data.push_back(obs_store_data);
            end
        end
        if (!hlt) begin
            timeouts++;
            $display("timeout: program %s never raised hlt", name);
        end
    endtask

    task automatic compare_stores(input string name);
        check(got_addr.size(), exp_addr.size(), {name, " store count"});
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check(got_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
            check(got_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
        end
    endtask

    task automatic simulate(input string name);
        predict_stores();
        execute_program(name);
        compare_stores(name);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic arith_ops();
        opcode_t ops [7] = '{OP_ADD, OP_SUB, OP_MUL, OP_AND, OP_OR, OP_XOR, OP_NOT};
        word_t   a, b;
        prog.delete();
        set_base();
        for (int round = 0; round < 2; round++) begin
            a = {$random(seed), $random(seed)};
            b = {$random(seed), $random(seed)};
            set_reg(1, a);
            set_reg(2, b);
            foreach (ops[k]) begin
                emit(ops[k], 3, 1, 2, 0);
                emit(OP_STORE, 30, 3, 0, 64 * round + 8 * k);
            end
        end
        emit(OP_HALT, 0, 0, 0, 0);
        simulate("arith");
    endtask

    task automatic imm_ops();
        word_t       a;
        logic [11:0] l;
        int          sh;
        prog.delete();
        set_base();
        a = {$random(seed), $random(seed)};
        l = $random(seed);
        sh = $random(seed) & 63;  // keep shift counts inside the word
        set_reg(1, a);
        set_small(2, sh);
        emit(OP_MOV_RS, 3, 1, 0, 0);
        emit(OP_ADDI, 3, 0, 0, l);
        emit(OP_STORE, 30, 3, 0, 0);
        emit(OP_MOV_RS, 3, 1, 0, 0);
        emit(OP_SUBI, 3, 0, 0, l);
        emit(OP_STORE, 30, 3, 0, 8);
        emit(OP_MOV_RS, 3, 1, 0, 0);
        emit(OP_SHFTRI, 3, 0, 0, sh);
        emit(OP_STORE, 30, 3, 0, 16);
        emit(OP_MOV_RS, 3, 1, 0, 0);
        emit(OP_SHFTLI, 3, 0, 0, sh);
        emit(OP_STORE, 30, 3, 0, 24);
        emit(OP_SHFTR, 3, 1, 2, 0);
        emit(OP_STORE, 30, 3, 0, 32);
        emit(OP_SHFTL, 3, 1, 2, 0);
        emit(OP_STORE, 30, 3, 0, 40);
        emit(OP_MOV_RS, 3, 1, 0, 0);
        emit(OP_MOV_L, 3, 0, 0, l);  // upper 52 bits of a survive
        emit(OP_STORE, 30, 3, 0, 48);
        emit(OP_HALT, 0, 0, 0, 0);
        simulate("immediate");
    endtask

    task automatic mem_round_trip();
        logic [11:0] l;
        prog.delete();
        set_base();
        l = $random(seed);
        set_reg(1, {$random(seed), $random(seed)});
        emit(OP_STORE, 30, 1, 0, l);
        emit(OP_LOAD, 2, 30, 0, l);
        emit(OP_STORE, 30, 2, 0, l ^ 12'h800);  // 2 KiB away, no overlap
        emit(OP_HALT, 0, 0, 0, 0);
        simulate("round trip");
    endtask

    task automatic branch_paths();
        int t [5];
        int back;
        prog.delete();
        set_base();
        set_small(1, 5);
        set_small(2, 0);
        set_small(4, 7);
        set_small(5, 3);
        emit(OP_SUB, 3, 2, 5, 0);  // r3 = -3
        set_small(6, 12'h5a);      // marker value
        set_small(7, 8);
        foreach (t[i]) load_target(10 + i, t[i]);
        emit(OP_BRNZ, 10, 2, 0, 0);   // not taken
        mark(1);
        emit(OP_BRNZ, 10, 1, 0, 0);   // taken
        mark(90);
        place_label(t[0]);
        mark(2);
        emit(OP_BRGT, 11, 3, 4, 0);   // -3 > 7 is false
        mark(3);
        emit(OP_BRGT, 11, 4, 3, 0);   // 7 > -3, false if unsigned
        mark(91);
        place_label(t[1]);
        mark(4);
        emit(OP_BR, 12, 0, 0, 0);
        mark(92);
        place_label(t[2]);
        mark(5);
        emit(OP_BRR_L, 0, 0, 0, 8);
        mark(93);
        mark(6);
        emit(OP_BR, 13, 0, 0, 0);     // jump over the block, come back with brr_l
        back = prog.size();
        mark(7);
        emit(OP_BR, 14, 0, 0, 0);
        place_label(t[3]);
        emit(OP_BRR_L, 0, 0, 0, 4 * (back - prog.size()));
        mark(94);
        place_label(t[4]);
        emit(OP_BRR_RD, 7, 0, 0, 0);
        mark(95);
        mark(8);
        emit(OP_HALT, 0, 0, 0, 0);
        simulate("branch");
    endtask

    task automatic halt_hold();
        prog.delete();
        set_base();
        set_small(6, 12'h77);
        mark(1);
        emit(OP_HALT, 0, 0, 0, 0);
        mark(2);  // must never issue
        simulate("halt");
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check(hlt, 1'b1, "hlt held after halt");
            check(obs_store_we, 1'b0, "store strobe after halt");
        end
        reset_req = 1'b1;
        @(negedge clk);
        check(hlt, 1'b0, "hlt cleared by reset");
    endtask

    initial begin
        int cycles;
        reset_req = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        cycles = 0;
        while (reset !== 1'b0 && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            timeouts++;
            $display("power-on reset was never released");
        end
        arith_ops();
        imm_ops();
        mem_round_trip();
        branch_paths();
        halt_hold();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
